//--- src.f
src/lsu_pkg.sv
src/lsu_align.sv
src/lsu_ctrl.sv
src/lsu_wbuf.sv
src/lsu_resp.sv
src/lsu_top.sv
testbench/lsu_asserts.sv
testbench/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the load/store unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f src.f -o lsu_sim

# The simulator exits non-zero on a fatal check, the log decides the result
./obj_dir/lsu_sim | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL"
  exit 1
fi

//--- testbench/lsu_tb.sv
/*
  Testbench for the load/store unit
  - Clock, reset and a table of requests with expected results
  - Bus memory model with random grant and response delay
  - Response monitor checking data, error and strobe timing
*/

module lsu_tb;
  import lsu_pkg::*;

  logic      clk, rst_n;
  logic      lsu_valid_i, lsu_we_i, lsu_signed_i, lsu_ready_o;
  lsu_size_e lsu_size_i;
  addr_t     lsu_addr_i, obi_addr_o;
  data_t     lsu_wdata_i, resp_rdata_o, obi_wdata_o, obi_rdata_i;
  logic      resp_valid_o, resp_err_o, busy_o;
  logic      obi_req_o, obi_we_o, obi_gnt_i, obi_rvalid_i, obi_err_i;
  be_t       obi_be_o;

  // Stimulus table, one entry per instruction
  logic      tab_we[$];
  lsu_size_e tab_size[$];
  logic      tab_signed[$];
  addr_t     tab_addr[$];
  data_t     tab_wdata[$];
  data_t     tab_rdata[$];
  logic      tab_err[$];

  // Bus model state
  data_t       mem [64];
  logic [31:0] rng_state = 32'h11b6;
  int          cycle = 0;
  int          due_q[$];
  data_t       rdata_q[$];
  logic        err_q[$];
  logic        stall_q = 1'b0;
  addr_t       held_addr;
  logic        held_we;
  be_t         held_be;
  data_t       held_wdata;

  // Response monitor state
  int          beats_q[$];
  int          beat_cnt = 0;
  int          resp_cnt = 0;
  logic        strobe_due = 1'b0;

  lsu_top lsu_top_inst (.*);

  always #10 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
      fail_now($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_now($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  task automatic add_op(input logic we, input lsu_size_e size, input logic sgn,
                        input addr_t addr, input data_t wdata, input data_t rdata,
                        input logic err);
    tab_we.push_back(we);
    tab_size.push_back(size);
    tab_signed.push_back(sgn);
    tab_addr.push_back(addr);
    tab_wdata.push_back(wdata);
    tab_rdata.push_back(rdata);
    tab_err.push_back(err);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // An access needs a second word when its bytes run past lane 3
  function automatic int beats_needed(input lsu_size_e size, input logic [1:0] off);
    int bytes;
    case (size)
      LSU_BYTE: bytes = 1;
      LSU_HALF: bytes = 2;
      default:  bytes = 4;
    endcase
    return (int'(off) + bytes > 4) ? 2 : 1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : bus_model
    logic [5:0] idx;
    logic       fault;
    data_t      mask;
    int         delay;
    rng_state = xorshift(rng_state);
    obi_gnt_i    <= rst_n && (rng_state[1:0] != 2'b00);
    obi_rvalid_i <= 1'b0;
    if (rst_n) begin
      // A stalled request must come back with the same address phase
      if (stall_q && (obi_req_o !== 1'b1 || obi_addr_o !== held_addr ||
          obi_we_o !== held_we || obi_be_o !== held_be || obi_wdata_o !== held_wdata))
        fail_now("Address phase changed while the request waited for grant");
      stall_q    = obi_req_o && !obi_gnt_i;
      held_addr  = obi_addr_o;
      held_we    = obi_we_o;
      held_be    = obi_be_o;
      held_wdata = obi_wdata_o;
      if (obi_req_o && obi_gnt_i) begin
        idx   = obi_addr_o[7:2];
        fault = (obi_addr_o >= 32'h100);
        mask  = {{8{obi_be_o[3]}}, {8{obi_be_o[2]}}, {8{obi_be_o[1]}}, {8{obi_be_o[0]}}};
        if (obi_we_o && !fault)
          mem[idx] = (mem[idx] & ~mask) | (obi_wdata_o & mask);
        rdata_q.push_back((obi_we_o || fault) ? 32'h0 : mem[idx]);
        err_q.push_back(fault);
        // Seen by the DUT 1 to 3 cycles after the grant
        delay = 1 + int'(rng_state[5:4]) % 3;
        due_q.push_back(cycle + delay - 1);
      end
      // One response per cycle, strictly in grant order
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        void'(due_q.pop_front());
        obi_rvalid_i <= 1'b1;
        obi_rdata_i  <= rdata_q.pop_front();
        obi_err_i    <= err_q.pop_front();
      end
      cycle++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : resp_monitor
    if (rst_n) begin
      if (lsu_valid_i && lsu_ready_o)
        beats_q.push_back(beats_needed(lsu_size_i, lsu_addr_i[1:0]));
      // The strobe must follow the last rvalid of its instruction by one cycle
      if (resp_valid_o !== strobe_due)
        fail_now($sformatf("Response strobe out of step with the bus at %0t", $time));
      else if (resp_valid_o && resp_cnt >= tab_we.size())
        fail_now("Response seen beyond the end of the table");
      else if (resp_valid_o) begin
        check_data($sformatf("resp_rdata_o (entry %0d)", resp_cnt), resp_rdata_o,
                   tab_rdata[resp_cnt]);
        check_err($sformatf("resp_err_o (entry %0d)", resp_cnt), resp_err_o,
                  tab_err[resp_cnt]);
        resp_cnt++;
      end
      strobe_due = 1'b0;
      if (obi_rvalid_i && beats_q.size() == 0)
        fail_now("Bus response arrived with no instruction waiting");
      else if (obi_rvalid_i) begin
        beat_cnt++;
        if (beat_cnt == beats_q[0]) begin
          strobe_due = 1'b1;
          beat_cnt   = 0;
          void'(beats_q.pop_front());
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [6:0] k;
    int         wait_cnt;
    clk          = 1'b0;
    rst_n        = 1'b0;
    lsu_valid_i  = 1'b0;
    lsu_we_i     = 1'b0;
    lsu_size_i   = LSU_WORD;
    lsu_signed_i = 1'b0;
    lsu_addr_i   = '0;
    lsu_wdata_i  = '0;
    obi_gnt_i    = 1'b0;
    obi_rvalid_i = 1'b0;
    obi_rdata_i  = '0;
    obi_err_i    = 1'b0;
    for (k = 7'd0; k < 7'd64; k++)
      mem[k[5:0]] = 32'hA0B0_C000 + {25'd0, k};

    // Aligned loads of the initial pattern
    add_op(1'b0, LSU_WORD, 1'b0, 32'h10, 32'h0, 32'hA0B0C004, 1'b0);
    add_op(1'b0, LSU_HALF, 1'b1, 32'h14, 32'h0, 32'hFFFFC005, 1'b0);
    add_op(1'b0, LSU_HALF, 1'b0, 32'h16, 32'h0, 32'h0000A0B0, 1'b0);
    add_op(1'b0, LSU_HALF, 1'b1, 32'h16, 32'h0, 32'hFFFFA0B0, 1'b0);
    add_op(1'b0, LSU_BYTE, 1'b1, 32'h1B, 32'h0, 32'hFFFFFFA0, 1'b0);
    add_op(1'b0, LSU_BYTE, 1'b0, 32'h19, 32'h0, 32'h000000C0, 1'b0);
    add_op(1'b0, LSU_BYTE, 1'b1, 32'h18, 32'h0, 32'h00000006, 1'b0);
    // Partial stores merged into one word
    add_op(1'b1, LSU_BYTE, 1'b0, 32'h21, 32'h0000005A, 32'h0, 1'b0);
    add_op(1'b1, LSU_HALF, 1'b0, 32'h22, 32'h00001234, 32'h0, 1'b0);
    add_op(1'b0, LSU_WORD, 1'b0, 32'h20, 32'h0, 32'h12345A08, 1'b0);
    add_op(1'b1, LSU_WORD, 1'b0, 32'h24, 32'hDEADBEEF, 32'h0, 1'b0);
    add_op(1'b0, LSU_WORD, 1'b0, 32'h24, 32'h0, 32'hDEADBEEF, 1'b0);
    // Accesses at offset 3 that cross into the next word
    add_op(1'b0, LSU_WORD, 1'b0, 32'h33, 32'h0, 32'hB0C00DA0, 1'b0);
    add_op(1'b0, LSU_HALF, 1'b1, 32'h37, 32'h0, 32'h00000EA0, 1'b0);
    add_op(1'b1, LSU_WORD, 1'b0, 32'h43, 32'h11223344, 32'h0, 1'b0);
    add_op(1'b0, LSU_WORD, 1'b0, 32'h40, 32'h0, 32'h44B0C010, 1'b0);
    add_op(1'b0, LSU_WORD, 1'b0, 32'h44, 32'h0, 32'hA0112233, 1'b0);
    add_op(1'b1, LSU_HALF, 1'b0, 32'h4B, 32'h0000BEEF, 32'h0, 1'b0);
    add_op(1'b0, LSU_WORD, 1'b0, 32'h48, 32'h0, 32'hEFB0C012, 1'b0);
    add_op(1'b0, LSU_WORD, 1'b0, 32'h4C, 32'h0, 32'hA0B0C0BE, 1'b0);
    add_op(1'b0, LSU_HALF, 1'b1, 32'h4B, 32'h0, 32'hFFFFBEEF, 1'b0);
    add_op(1'b0, LSU_HALF, 1'b0, 32'h4B, 32'h0, 32'h0000BEEF, 1'b0);
    // Bus errors, the split load faults only in its upper word
    add_op(1'b0, LSU_WORD, 1'b0, 32'h100, 32'h0, 32'h0, 1'b1);
    add_op(1'b0, LSU_WORD, 1'b0, 32'hFE, 32'h0, 32'h0000A0B0, 1'b1);
    add_op(1'b1, LSU_WORD, 1'b0, 32'h104, 32'h12345678, 32'h0, 1'b1);
    add_op(1'b0, LSU_BYTE, 1'b0, 32'h3F, 32'h0, 32'h000000A0, 1'b0);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Requests go out back to back, responses are checked by the monitor
    for (int i = 0; i < tab_we.size(); i++) begin
      lsu_valid_i  <= 1'b1;
      lsu_we_i     <= tab_we[i];
      lsu_size_i   <= tab_size[i];
      lsu_signed_i <= tab_signed[i];
      lsu_addr_i   <= tab_addr[i];
      lsu_wdata_i  <= tab_wdata[i];
      wait_cnt = 0;
      @(negedge clk);
      while (!lsu_ready_o) begin
        wait_cnt++;
        if (wait_cnt > 200)
          fail_now($sformatf("Timeout waiting for lsu_ready_o on entry %0d", i));
        else
          @(negedge clk);
      end
      @(posedge clk);
    end
    lsu_valid_i <= 1'b0;

    wait_cnt = 0;
    while (resp_cnt < tab_we.size()) begin
      wait_cnt++;
      if (wait_cnt > 200)
        fail_now($sformatf("Timeout waiting for responses, %0d received", resp_cnt));
      else
        @(negedge clk);
    end
    @(negedge clk);
    if (busy_o !== 1'b0 || obi_req_o !== 1'b0)
      fail_now("Unit still busy after the last response");
    else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- testbench/lsu_asserts.sv
/*
  Concurrent checks bound into the load/store control block
  - Outstanding transfer count never above the bus depth
  - Responses only while a transfer is outstanding
  - Busy once a transfer has been granted
  - Request held while the bus withholds grant
*/

module lsu_asserts (
  input  logic                 clk,
  input  logic                 rst_n,
  input  lsu_pkg::cnt_t        cnt_i,
  input  logic                 obi_req_i,
  input  logic                 obi_gnt_i,
  input  logic                 obi_rvalid_i,
  input  logic                 busy_i,
  input  lsu_pkg::wbuf_state_e wbuf_state_i
);
  import lsu_pkg::*;

  cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    32'(cnt_i) <= LSU_DEPTH)
    else $error("outstanding transfer count above the bus depth");

  // Every rvalid needs a granted transfer that is still open
  rvalid_open: assert property (@(posedge clk) disable iff (!rst_n)
    obi_rvalid_i |-> (cnt_i != '0))
    else $error("rvalid without an outstanding transfer");

  // A granted transfer is still outstanding in the cycle after its grant
  busy_grant: assert property (@(posedge clk) disable iff (!rst_n)
    (obi_req_i && obi_gnt_i) |=> busy_i)
    else $error("busy low with transfers outstanding");

  // A stalled request stays up and its entry stays in the buffer
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (obi_req_i && !obi_gnt_i) |=> (obi_req_i && (wbuf_state_i == WBUF_FULL)))
    else $error("request dropped before grant");

endmodule

bind lsu_ctrl lsu_asserts lsu_asserts_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .cnt_i        (cnt_q),
  .obi_req_i    (obi_req_i),
  .obi_gnt_i    (obi_gnt_i),
  .obi_rvalid_i (obi_rvalid_i),
  .busy_i       (busy_o),
  .wbuf_state_i (wbuf_state_i)
);

//--- src/lsu_top.sv
/*
  Load/store unit top level
  - Execute side request and response ports
  - OBI-style data bus ports
  - Alignment, control, write buffer and response tracker
*/

module lsu_top (
  input  logic               clk,
  input  logic               rst_n,
  // Execute side
  input  logic               lsu_valid_i,
  input  logic               lsu_we_i,
  input  lsu_pkg::lsu_size_e lsu_size_i,
  input  logic               lsu_signed_i,
  input  lsu_pkg::addr_t     lsu_addr_i,
  input  lsu_pkg::data_t     lsu_wdata_i,
  output logic               lsu_ready_o,
  output logic               resp_valid_o,
  output lsu_pkg::data_t     resp_rdata_o,
  output logic               resp_err_o,
  output logic               busy_o,
  // Data bus
  output logic               obi_req_o,
  output lsu_pkg::addr_t     obi_addr_o,
  output logic               obi_we_o,
  output lsu_pkg::be_t       obi_be_o,
  output lsu_pkg::data_t     obi_wdata_o,
  input  logic               obi_gnt_i,
  input  logic               obi_rvalid_i,
  input  lsu_pkg::data_t     obi_rdata_i,
  input  logic               obi_err_i
);
  import lsu_pkg::*;

  // Candidate transfers from the alignment stage
  logic        split;
  addr_t       addr0, addr1;
  be_t         be0, be1;
  data_t       wdata0, wdata1;

  // Transfer handed from control to the write buffer
  logic        trans_valid;
  addr_t       trans_addr;
  logic        trans_we;
  be_t         trans_be;
  data_t       trans_wdata;
  logic        wbuf_ready;
  wbuf_state_e wbuf_state;
  logic        push;

  lsu_align lsu_align_inst (
    .addr_i   (lsu_addr_i),
    .size_i   (lsu_size_i),
    .wdata_i  (lsu_wdata_i),
    .split_o  (split),
    .addr0_o  (addr0),
    .addr1_o  (addr1),
    .be0_o    (be0),
    .be1_o    (be1),
    .wdata0_o (wdata0),
    .wdata1_o (wdata1)
  );

  lsu_ctrl lsu_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .lsu_valid_i   (lsu_valid_i),
    .lsu_we_i      (lsu_we_i),
    .split_i       (split),
    .addr0_i       (addr0),
    .addr1_i       (addr1),
    .be0_i         (be0),
    .be1_i         (be1),
    .wdata0_i      (wdata0),
    .wdata1_i      (wdata1),
    .lsu_ready_o   (lsu_ready_o),
    .trans_valid_o (trans_valid),
    .trans_addr_o  (trans_addr),
    .trans_we_o    (trans_we),
    .trans_be_o    (trans_be),
    .trans_wdata_o (trans_wdata),
    .wbuf_ready_i  (wbuf_ready),
    .obi_gnt_i     (obi_gnt_i),
    .obi_req_i     (obi_req_o),
    .obi_rvalid_i  (obi_rvalid_i),
    .busy_o        (busy_o),
    .wbuf_state_i  (wbuf_state),
    .push_o        (push)
  );

  lsu_wbuf lsu_wbuf_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_addr_i  (trans_addr),
    .trans_we_i    (trans_we),
    .trans_be_i    (trans_be),
    .trans_wdata_i (trans_wdata),
    .wbuf_ready_o  (wbuf_ready),
    .wbuf_state_o  (wbuf_state),
    .obi_req_o     (obi_req_o),
    .obi_addr_o    (obi_addr_o),
    .obi_we_o      (obi_we_o),
    .obi_be_o      (obi_be_o),
    .obi_wdata_o   (obi_wdata_o),
    .obi_gnt_i     (obi_gnt_i)
  );

  // The descriptor is taken straight from the execute side request
  lsu_resp lsu_resp_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_i        (push),
    .push_split_i  (split),
    .push_size_i   (lsu_size_i),
    .push_signed_i (lsu_signed_i),
    .push_offset_i (lsu_addr_i[1:0]),
    .push_we_i     (lsu_we_i),
    .obi_rvalid_i  (obi_rvalid_i),
    .obi_rdata_i   (obi_rdata_i),
    .obi_err_i     (obi_err_i),
    .resp_valid_o  (resp_valid_o),
    .resp_rdata_o  (resp_rdata_o),
    .resp_err_o    (resp_err_o)
  );

endmodule

//--- src/lsu_resp.sv
/*
  Response tracker of the load/store unit
  - In-order queue of instruction descriptors
  - Holds the first word and error of a split load
  - Realigns, merges and extends the load data
  - Registers the result into a one-cycle response strobe
*/

module lsu_resp (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               push_i,
  input  logic               push_split_i,
  input  lsu_pkg::lsu_size_e push_size_i,
  input  logic               push_signed_i,
  input  logic [1:0]         push_offset_i,
  input  logic               push_we_i,
  input  logic               obi_rvalid_i,
  input  lsu_pkg::data_t     obi_rdata_i,
  input  logic               obi_err_i,
  output logic               resp_valid_o,
  output lsu_pkg::data_t     resp_rdata_o,
  output logic               resp_err_o
);
  import lsu_pkg::*;

  // Descriptor queue, one entry per instruction in flight
  logic       q_split  [LSU_DEPTH];
  lsu_size_e  q_size   [LSU_DEPTH];
  logic       q_signed [LSU_DEPTH];
  logic [1:0] q_offset [LSU_DEPTH];
  logic       q_we     [LSU_DEPTH];

  logic [$clog2(LSU_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;

  // Set after the first response of a split entry has arrived
  logic        half_q;
  data_t       first_q;
  logic        first_err_q;

  logic        last_beat;
  logic [63:0] merged;
  data_t       ext;
  logic        err;

  // The head entry is done on its only or its second response
  assign last_beat = obi_rvalid_i && (!q_split[rd_ptr_q] || half_q);

  always_comb begin
    // Lay both words side by side and shift the access down to lane 0
    merged = q_split[rd_ptr_q] ? {obi_rdata_i, first_q} : {32'h0000_0000, obi_rdata_i};
    merged = merged >> {q_offset[rd_ptr_q], 3'b000};

    case (q_size[rd_ptr_q])
      LSU_BYTE: ext = q_signed[rd_ptr_q] ? {{24{merged[7]}}, merged[7:0]}
                                         : {24'h00_0000, merged[7:0]};
      LSU_HALF: ext = q_signed[rd_ptr_q] ? {{16{merged[15]}}, merged[15:0]}
                                         : {16'h0000, merged[15:0]};
      default:  ext = merged[31:0];
    endcase

    // Stores return no data
    if (q_we[rd_ptr_q]) begin
      ext = '0;
    end

    err = obi_err_i || (q_split[rd_ptr_q] && first_err_q);
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      half_q       <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (last_beat) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (obi_rvalid_i) half_q <= !last_beat;
      resp_valid_o <= last_beat;
    end
  end

  // Queue contents, first half and result need no reset
  always_ff @(posedge clk) begin
    if (push_i) begin
      q_split[wr_ptr_q]  <= push_split_i;
      q_size[wr_ptr_q]   <= push_size_i;
      q_signed[wr_ptr_q] <= push_signed_i;
      q_offset[wr_ptr_q] <= push_offset_i;
      q_we[wr_ptr_q]     <= push_we_i;
    end
    if (obi_rvalid_i && !last_beat) begin
      first_q     <= obi_rdata_i;
      first_err_q <= obi_err_i;
    end
    if (last_beat) begin
      resp_rdata_o <= ext;
      resp_err_o   <= err;
    end
  end

endmodule

//--- src/lsu_wbuf.sv
/*
  One-entry write buffer of the load/store unit
  - Holds a transfer while the bus withholds grant
  - Drives the bus address phase straight from its registers
  - Refills in the cycle its current entry is granted
*/

module lsu_wbuf (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 trans_valid_i,
  input  lsu_pkg::addr_t       trans_addr_i,
  input  logic                 trans_we_i,
  input  lsu_pkg::be_t         trans_be_i,
  input  lsu_pkg::data_t       trans_wdata_i,
  output logic                 wbuf_ready_o,
  output lsu_pkg::wbuf_state_e wbuf_state_o,
  output logic                 obi_req_o,
  output lsu_pkg::addr_t       obi_addr_o,
  output logic                 obi_we_o,
  output lsu_pkg::be_t         obi_be_o,
  output lsu_pkg::data_t       obi_wdata_o,
  input  logic                 obi_gnt_i
);
  import lsu_pkg::*;

  wbuf_state_e state_q;
  logic        granted;
  logic        load;

  // The request is simply the occupancy of the buffer
  assign obi_req_o    = (state_q == WBUF_FULL);
  assign wbuf_state_o = state_q;

  assign granted = obi_req_o && obi_gnt_i;

  // Space exists when empty or when the entry leaves in this cycle
  assign wbuf_ready_o = (state_q == WBUF_EMPTY) || granted;
  assign load         = trans_valid_i && wbuf_ready_o;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WBUF_EMPTY;
    end else if (load) begin
      state_q <= WBUF_FULL;
    end else if (granted) begin
      state_q <= WBUF_EMPTY;
    end
  end

  // The address phase only changes on a load, so it stays stable
  // for as long as the request waits for grant
  always_ff @(posedge clk) begin
    if (load) begin
      obi_addr_o  <= trans_addr_i;
      obi_we_o    <= trans_we_i;
      obi_be_o    <= trans_be_i;
      obi_wdata_o <= trans_wdata_i;
    end
  end

endmodule

//--- src/lsu_ctrl.sv
/*
  Control block of the load/store unit
  - Split FSM that issues the second half of a crossing access
  - Counter of granted but unanswered bus transfers
  - Ready towards the execute stage and busy towards the core
  - Push strobe for the response tracker
*/

module lsu_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 lsu_valid_i,
  input  logic                 lsu_we_i,
  input  logic                 split_i,
  input  lsu_pkg::addr_t       addr0_i,
  input  lsu_pkg::addr_t       addr1_i,
  input  lsu_pkg::be_t         be0_i,
  input  lsu_pkg::be_t         be1_i,
  input  lsu_pkg::data_t       wdata0_i,
  input  lsu_pkg::data_t       wdata1_i,
  output logic                 lsu_ready_o,
  output logic                 trans_valid_o,
  output lsu_pkg::addr_t       trans_addr_o,
  output logic                 trans_we_o,
  output lsu_pkg::be_t         trans_be_o,
  output lsu_pkg::data_t       trans_wdata_o,
  input  logic                 wbuf_ready_i,
  input  logic                 obi_gnt_i,
  input  logic                 obi_req_i,
  input  logic                 obi_rvalid_i,
  output logic                 busy_o,
  input  lsu_pkg::wbuf_state_e wbuf_state_i,
  output logic                 push_o
);
  import lsu_pkg::*;

  split_state_e state_q, state_d;
  cnt_t         cnt_q, cnt_d;
  logic         accept;
  logic         count_up;
  logic         count_down;
  // Transfers already committed plus the ones a new request would add
  logic [2:0]   commit_total;

  // Second half of a split request, held until the buffer takes it
  addr_t        addr1_q;
  be_t          be1_q;
  data_t        wdata1_q;
  logic         we1_q;

  //////////////////////////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////////////////////////

  // A full buffer holds one more transfer that will reach the counter
  assign commit_total = {1'b0, cnt_q} + {2'b00, (wbuf_state_i == WBUF_FULL)}
                      + (split_i ? 3'd2 : 3'd1);

  // No new request while the second half is pending, while the buffer
  // is blocked, or when the new transfers would overrun the bus depth
  assign lsu_ready_o = (state_q == SPLIT_IDLE) && wbuf_ready_i &&
                       (commit_total <= 3'(LSU_DEPTH));

  assign accept = lsu_valid_i && lsu_ready_o;

  // Every accepted instruction gets one descriptor in the tracker
  assign push_o = accept;

  // Transfer mux, the held second half wins over a new request
  always_comb begin
    if (state_q == SPLIT_SECOND) begin
      trans_valid_o = 1'b1;
      trans_addr_o  = addr1_q;
      trans_we_o    = we1_q;
      trans_be_o    = be1_q;
      trans_wdata_o = wdata1_q;
    end else begin
      trans_valid_o = accept;
      trans_addr_o  = addr0_i;
      trans_we_o    = lsu_we_i;
      trans_be_o    = be0_i;
      trans_wdata_o = wdata0_i;
    end
  end

  // Split FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      SPLIT_IDLE:   if (accept && split_i) state_d = SPLIT_SECOND;
      SPLIT_SECOND: if (wbuf_ready_i) state_d = SPLIT_IDLE;
      default:      state_d = SPLIT_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Outstanding transfers
  //////////////////////////////////////////////////////////////////////

  // A transfer counts from its grant until its response
  assign count_up   = obi_req_i && obi_gnt_i;
  assign count_down = obi_rvalid_i;
  assign cnt_d      = cnt_q + {1'b0, count_up} - {1'b0, count_down};

  assign busy_o = (cnt_q != '0) || (wbuf_state_i == WBUF_FULL);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= SPLIT_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Capture the upper half when a split request is accepted
  always_ff @(posedge clk) begin
    if (accept && split_i) begin
      addr1_q  <= addr1_i;
      be1_q    <= be1_i;
      wdata1_q <= wdata1_i;
      we1_q    <= lsu_we_i;
    end
  end

endmodule

//--- src/lsu_align.sv
/*
  Alignment stage of the load/store unit
  - Byte enables from access size and low address bits
  - Store data rotated into its byte lanes
  - Second word transfer for accesses that cross a word boundary
*/

module lsu_align (
  input  lsu_pkg::addr_t     addr_i,
  input  lsu_pkg::lsu_size_e size_i,
  input  lsu_pkg::data_t     wdata_i,
  output logic               split_o,
  output lsu_pkg::addr_t     addr0_o,
  output lsu_pkg::addr_t     addr1_o,
  output lsu_pkg::be_t       be0_o,
  output lsu_pkg::be_t       be1_o,
  output lsu_pkg::data_t     wdata0_o,
  output lsu_pkg::data_t     wdata1_o
);
  import lsu_pkg::*;

  // Byte offset of the access inside its first word
  logic [1:0]  offset;
  // Enables for the access before it is moved to its offset
  be_t         size_mask;
  // Enables and data spread over two consecutive words
  logic [7:0]  be_wide;
  logic [63:0] wdata_wide;

  always_comb begin
    offset = addr_i[1:0];

    // Lanes covered by the access when it starts at lane 0
    case (size_i)
      LSU_BYTE: size_mask = 4'b0001;
      LSU_HALF: size_mask = 4'b0011;
      default:  size_mask = 4'b1111;
    endcase

    // Move enables and data up by the offset, lanes that spill past
    // lane 3 land in the upper word and form the second transfer
    be_wide    = {4'b0000, size_mask} << offset;
    wdata_wide = {32'h0000_0000, wdata_i} << {offset, 3'b000};
  end

  // A split is needed as soon as any lane falls into the next word
  assign split_o = |be_wide[7:4];

  // First transfer keeps the lower lanes
  assign be0_o    = be_wide[3:0];
  assign wdata0_o = wdata_wide[31:0];

  // Second transfer carries whatever is left over
  assign be1_o    = be_wide[7:4];
  assign wdata1_o = wdata_wide[63:32];

  // Both transfers address whole words, the second one the next word up
  assign addr0_o = {addr_i[31:2], 2'b00};
  assign addr1_o = addr0_o + 32'd4;

endmodule

//--- src/lsu_pkg.sv
/*
  Shared definitions for the load/store unit
  - Address, data and byte enable vector types
  - Access size encoding
  - State encodings for the split FSM and the write buffer
  - Outstanding transfer count type and maximum bus depth
*/

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  // Byte address as seen by the core and the data bus
  typedef logic [31:0] addr_t;

  // One 32-bit data word on either side of the unit
  typedef logic [31:0] data_t;

  // One enable bit per byte lane of a data word
  typedef logic [3:0] be_t;

  // Number of transfers granted on the bus but not yet answered
  typedef logic [1:0] cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Access size as requested by the execute stage
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // The split FSM waits in SPLIT_SECOND until the second half is buffered
  typedef enum logic {
    SPLIT_IDLE   = 1'b0,
    SPLIT_SECOND = 1'b1
  } split_state_e;

  // Occupancy of the one-entry write buffer
  typedef enum logic {
    WBUF_EMPTY = 1'b0,
    WBUF_FULL  = 1'b1
  } wbuf_state_e;

  // Maximum number of bus transfers in flight at any time
  localparam int unsigned LSU_DEPTH = 2;

endpackage
